// File: design/avalon_spi_config.svh
`ifndef AVALON_SPI_CONFIG_SVH
`define AVALON_SPI_CONFIG_SVH

// avalon bus widths
`define AVS_ADDR_W 8
`define AVS_DATA_W 32

// register map, one word per address
`define AVS_ADDR_CONTROL 8'h00
`define AVS_ADDR_STATUS 8'h01
`define AVS_ADDR_DATA_WR 8'h02
`define AVS_ADDR_DATA_RD 8'h03

// start bits inside the control word
`define AVS_CTRL_WR_BIT 0
`define AVS_CTRL_RD_BIT 1

`endif

// File: design/avalon_spi_pkg.sv
`default_nettype none

`include "avalon_spi_config.svh"

package avalon_spi_pkg;

	typedef logic [`AVS_ADDR_W-1:0] addr_t;
	typedef logic [`AVS_DATA_W-1:0] data_t;

	// everything the avalon master drives
	typedef struct packed
	{
		logic chip_select;
		logic read;
		logic write;
		addr_t address;
		data_t write_data;
	} avs_req_t;

	// bus fsm to register block
	typedef struct packed
	{
		logic read_load;
		logic write_commit;
		addr_t address;
	} reg_access_t;

	// start levels from the control register
	typedef struct packed
	{
		logic start_write;
		logic start_read;
	} spi_cmd_t;

	// status field, as seen at address 0x01
	typedef enum logic [1:0]
	{
		status_idle = 2'd0,
		status_write_busy = 2'd1,
		status_read_busy = 2'd2,
		status_read_ready = 2'd3
	} spi_status_t;

	// to the spi engine
	typedef struct packed
	{
		logic go_transfer;
		data_t tx_data;
	} spi_req_t;

	// from the spi engine
	typedef struct packed
	{
		logic pack_ready;
		data_t rx_data;
	} spi_rsp_t;

	typedef enum logic [1:0]
	{
		bus_reset,
		bus_idle,
		bus_write,
		bus_read
	} bus_state_t;

	typedef enum logic [2:0]
	{
		seq_idle,
		seq_write_start,
		seq_write_wait,
		seq_read_start,
		seq_read_wait,
		seq_read_done
	} seq_state_t;

endpackage

`default_nettype wire

// File: design/bus_access_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module bus_access_fsm
	import avalon_spi_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire avs_req_t avs_req,
	output logic wait_request,
	output reg_access_t reg_access
);

	////////////////////////////////////////////////////////////
	// edge detection on the bus levels
	////////////////////////////////////////////////////////////

	logic access_level;
	logic level_d1;
	logic level_d2;
	logic write_d1;
	logic write_d2;
	logic read_d1;
	logic read_d2;
	logic write_strobe;
	logic read_strobe;
	bus_state_t state;
	bus_state_t state_next;

	// read or write, whichever the master holds
	assign access_level = avs_req.read | avs_req.write;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			level_d1 <= 1'b0;
			level_d2 <= 1'b0;
			write_d1 <= 1'b0;
			write_d2 <= 1'b0;
			read_d1 <= 1'b0;
			read_d2 <= 1'b0;
		end
		else
		begin
			level_d1 <= access_level;
			level_d2 <= level_d1;
			write_d1 <= avs_req.write;
			write_d2 <= write_d1;
			read_d1 <= avs_req.read;
			read_d2 <= read_d1;
		end
	end

	// high from the level rising up to the third edge
	assign wait_request = access_level & ~level_d2;

	// one cycle each, between the first and second edge
	assign write_strobe = write_d1 & ~write_d2;
	assign read_strobe = read_d1 & ~read_d2;

	////////////////////////////////////////////////////////////
	// access state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			state <= bus_reset;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			bus_reset:
				state_next = bus_idle;
			bus_idle:
			begin
				// deselected accesses only stretch, nothing else
				if (avs_req.chip_select && write_strobe)
					state_next = bus_write;
				else if (avs_req.chip_select && read_strobe)
					state_next = bus_read;
			end
			bus_write:
				state_next = bus_idle;
			bus_read:
				state_next = bus_idle;
			default:
				state_next = bus_idle;
		endcase
	end

	// read data loads at the edge entering bus_read
	always_comb
	begin
		reg_access.read_load = (state == bus_idle) && (state_next == bus_read);
		reg_access.write_commit = (state == bus_write);
		reg_access.address = avs_req.address;
	end

endmodule

`default_nettype wire

// File: design/bridge_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "avalon_spi_config.svh"

module bridge_regs
	import avalon_spi_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire data_t write_data,
	input wire reg_access_t reg_access,
	input wire spi_status_t status,
	input wire data_t rx_word,
	output spi_cmd_t spi_cmd,
	output data_t tx_word,
	output data_t read_data
);

	spi_cmd_t ctrl_q;
	data_t data_wr_q;
	data_t read_mux;
	logic sel_control;
	logic sel_data_wr;

	// write side decode
	assign sel_control = (reg_access.address == `AVS_ADDR_CONTROL);
	assign sel_data_wr = (reg_access.address == `AVS_ADDR_DATA_WR);

	////////////////////////////////////////////////////////////
	// writable registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			ctrl_q <= '0;
			data_wr_q <= '0;
		end
		else if (reg_access.write_commit)
		begin
			// only the two start bits are kept
			if (sel_control)
			begin
				ctrl_q.start_write <= write_data[`AVS_CTRL_WR_BIT];
				ctrl_q.start_read <= write_data[`AVS_CTRL_RD_BIT];
			end
			if (sel_data_wr)
				data_wr_q <= write_data;
		end
	end

	assign spi_cmd = ctrl_q;
	assign tx_word = data_wr_q;

	////////////////////////////////////////////////////////////
	// read path
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (reg_access.address)
			`AVS_ADDR_STATUS:
				read_mux = {{(`AVS_DATA_W-2){1'b0}}, status};
			`AVS_ADDR_DATA_RD:
				read_mux = rx_word;
			// unmapped reads give zero
			default:
				read_mux = '0;
		endcase
	end

	// held until the next read access
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			read_data <= '0;
		else if (reg_access.read_load)
			read_data <= read_mux;
	end

endmodule

`default_nettype wire

// File: design/spi_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module spi_sequencer
	import avalon_spi_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire spi_cmd_t spi_cmd,
	input wire data_t tx_word,
	input wire spi_rsp_t spi_rsp,
	output spi_req_t spi_req,
	output logic transfer_complete,
	output spi_status_t status,
	output data_t rx_word
);

	logic wr_d1;
	logic wr_d2;
	logic rd_d1;
	logic rd_d2;
	logic pr_d1;
	logic pr_d2;
	logic wr_edge;
	logic rd_edge;
	logic rx_capture;
	seq_state_t state;
	seq_state_t state_next;

	////////////////////////////////////////////////////////////
	// command and completion edges
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			wr_d1 <= 1'b0;
			wr_d2 <= 1'b0;
			rd_d1 <= 1'b0;
			rd_d2 <= 1'b0;
			pr_d1 <= 1'b0;
			pr_d2 <= 1'b0;
		end
		else
		begin
			wr_d1 <= spi_cmd.start_write;
			wr_d2 <= wr_d1;
			rd_d1 <= spi_cmd.start_read;
			rd_d2 <= rd_d1;
			pr_d1 <= spi_rsp.pack_ready;
			pr_d2 <= pr_d1;
		end
	end

	assign wr_edge = wr_d1 & ~wr_d2;
	assign rd_edge = rd_d1 & ~rd_d2;

	// engine busy window has just closed
	assign transfer_complete = pr_d2 & ~pr_d1;

	////////////////////////////////////////////////////////////
	// transfer state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			state <= seq_idle;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			// write wins when both bits rise together
			seq_idle, seq_read_done:
			begin
				if (wr_edge)
					state_next = seq_write_start;
				else if (rd_edge)
					state_next = seq_read_start;
			end
			seq_write_start:
				state_next = seq_write_wait;
			seq_read_start:
				state_next = seq_read_wait;
			seq_write_wait:
			begin
				if (transfer_complete)
					state_next = seq_idle;
			end
			seq_read_wait:
			begin
				if (transfer_complete)
					state_next = seq_read_done;
			end
			default:
				state_next = seq_idle;
		endcase
	end

	// one cycle kick per command
	always_comb
	begin
		spi_req.go_transfer = (state == seq_write_start) || (state == seq_read_start);
		spi_req.tx_data = tx_word;
	end

	// status lags the state by one edge
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			status <= status_idle;
		else
		begin
			case (state)
				seq_write_start:
					status <= status_write_busy;
				seq_read_start:
					status <= status_read_busy;
				seq_write_wait:
				begin
					if (transfer_complete)
						status <= status_idle;
				end
				seq_read_wait:
				begin
					// read_ready stays until a new start state
					if (transfer_complete)
						status <= status_read_ready;
				end
				default:
					status <= status;
			endcase
		end
	end

	// first edge with pack_ready low, one ahead of the complete pulse
	assign rx_capture = (state == seq_read_wait) && pr_d1 && !spi_rsp.pack_ready;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			rx_word <= '0;
		else if (rx_capture)
			rx_word <= spi_rsp.rx_data;
	end

endmodule

`default_nettype wire

// File: design/avalon_spi_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module avalon_spi_bridge
	import avalon_spi_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire avs_req_t avs_req,
	output logic wait_request,
	output data_t read_data,
	output spi_req_t spi_req,
	input wire spi_rsp_t spi_rsp,
	output logic transfer_complete
);

	reg_access_t reg_access;
	spi_cmd_t spi_cmd;
	data_t tx_word;
	data_t rx_word;
	spi_status_t status;

	// avalon side, wait states and access strobes
	bus_access_fsm u_bus_access_fsm (
		.clk (clk),
		.reset_n (reset_n),
		.avs_req (avs_req),
		.wait_request (wait_request),
		.reg_access (reg_access)
	);

	// register map
	bridge_regs u_bridge_regs (
		.clk (clk),
		.reset_n (reset_n),
		.write_data (avs_req.write_data),
		.reg_access (reg_access),
		.status (status),
		.rx_word (rx_word),
		.spi_cmd (spi_cmd),
		.tx_word (tx_word),
		.read_data (read_data)
	);

	// spi engine handshake
	spi_sequencer u_spi_sequencer (
		.clk (clk),
		.reset_n (reset_n),
		.spi_cmd (spi_cmd),
		.tx_word (tx_word),
		.spi_rsp (spi_rsp),
		.spi_req (spi_req),
		.transfer_complete (transfer_complete),
		.status (status),
		.rx_word (rx_word)
	);

endmodule

`default_nettype wire

// File: bench/spi_engine_model.sv
`timescale 1ns/10ps
`default_nettype none

module spi_engine_model
	import avalon_spi_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire spi_req_t spi_req,
	input wire logic [4:0] busy_len,
	input wire data_t word,
	output spi_rsp_t spi_rsp
);

	logic [4:0] busy_left;

	// busy window length and reply word come from the testbench
	always @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			spi_rsp <= '0;
			busy_left <= '0;
		end
		else if (spi_req.go_transfer && !spi_rsp.pack_ready)
		begin
			spi_rsp.pack_ready <= 1'b1;
			spi_rsp.rx_data <= word;
			busy_left <= busy_len;
		end
		else if (spi_rsp.pack_ready)
		begin
			// falling pack_ready ends the transfer
			if (busy_left <= 5'd1)
				spi_rsp.pack_ready <= 1'b0;
			else
				busy_left <= busy_left - 5'd1;
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_avalon_spi_bridge.sv
`timescale 1ns/10ps
`default_nettype none

`include "avalon_spi_config.svh"

module tb_avalon_spi_bridge
	import avalon_spi_pkg::*;
();

	// five tests of at most 400 cycles each
	localparam int timeout_cycles = 2000;

	logic clk = 1'b0;
	logic reset_n;
	avs_req_t avs_req;
	logic wait_request;
	data_t read_data;
	spi_req_t spi_req;
	spi_rsp_t spi_rsp;
	logic transfer_complete;
	logic [4:0] engine_len;
	data_t engine_word;
	data_t tx_expect;
	int err_count = 0;
	int go_count = 0;
	int done_count = 0;
	int cycle_count = 0;

	always #5 clk = ~clk;

	avalon_spi_bridge u_dut (
		.clk (clk),
		.reset_n (reset_n),
		.avs_req (avs_req),
		.wait_request (wait_request),
		.read_data (read_data),
		.spi_req (spi_req),
		.spi_rsp (spi_rsp),
		.transfer_complete (transfer_complete)
	);

	spi_engine_model u_engine (
		.clk (clk),
		.reset_n (reset_n),
		.spi_req (spi_req),
		.busy_len (engine_len),
		.word (engine_word),
		.spi_rsp (spi_rsp)
	);

	////////////////////////////////////////////////////////////
	// pulse counters and run limit
	////////////////////////////////////////////////////////////

	// pulses counted at the falling clock edge
	always @(negedge clk)
	begin
		if (reset_n && spi_req.go_transfer)
			go_count = go_count + 1;
		if (reset_n && transfer_complete)
			done_count = done_count + 1;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			err_count = err_count + 1;
			$display("timeout, run stopped after %0d cycles", cycle_count);
			$display("checks done, %0d errors", err_count);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
		begin
			err_count = err_count + 1;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input spi_status_t got,
		input spi_status_t exp);
		if (got !== exp)
		begin
			err_count = err_count + 1;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			err_count = err_count + 1;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			err_count = err_count + 1;
			$display("%s pulsed %0d times where %0d pulses were expected", name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// bus and engine helpers
	////////////////////////////////////////////////////////////

	// wait_request must read high at E0 and E1 and low at E2
	task automatic step_wait_states();
		@(negedge clk);
		check_bit("wait_request", wait_request, 1'b1);
		@(posedge clk);
		@(negedge clk);
		check_bit("wait_request", wait_request, 1'b1);
		@(posedge clk);
		@(negedge clk);
		check_bit("wait_request", wait_request, 1'b0);
		@(posedge clk);
	endtask

	task automatic bus_write(input addr_t addr, input data_t data, input logic cs);
		@(posedge clk);
		avs_req.chip_select <= cs;
		avs_req.write <= 1'b1;
		avs_req.address <= addr;
		avs_req.write_data <= data;
		step_wait_states();
		// accepted at E2 and followed by two idle edges
		avs_req <= '0;
		repeat (2) @(posedge clk);
	endtask

	task automatic bus_read(input addr_t addr, output data_t data);
		@(posedge clk);
		avs_req.chip_select <= 1'b1;
		avs_req.read <= 1'b1;
		avs_req.address <= addr;
		step_wait_states();
		data = read_data;
		avs_req <= '0;
		repeat (2) @(posedge clk);
	endtask

	// busy window of 4 to 20 cycles and a fresh reply word
	task automatic arm_engine(output data_t word);
		int span;
		begin
			span = $urandom % 17;
			word = $urandom;
			engine_len <= 5'd4 + span[4:0];
			engine_word <= word;
		end
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset();
		data_t rd;
		begin
			check_bit("wait_request", wait_request, 1'b0);
			check_bit("go_transfer", spi_req.go_transfer, 1'b0);
			check_bit("transfer_complete", transfer_complete, 1'b0);
			bus_read(`AVS_ADDR_STATUS, rd);
			check_data("status", rd, 32'h0);
			bus_read(`AVS_ADDR_DATA_RD, rd);
			check_data("data_rd", rd, 32'h0);
		end
	endtask

	task automatic test_data_write();
		tx_expect = $urandom;
		bus_write(`AVS_ADDR_DATA_WR, tx_expect, 1'b1);
		check_data("tx_data", spi_req.tx_data, tx_expect);
	endtask

	task automatic test_spi_write();
		int go_before;
		int done_before;
		data_t word;
		data_t rd;
		begin
			go_before = go_count;
			done_before = done_count;
			arm_engine(word);
			bus_write(`AVS_ADDR_CONTROL, 32'h1, 1'b1);
			while (go_count == go_before)
				@(posedge clk);
			bus_read(`AVS_ADDR_STATUS, rd);
			check_status("status", spi_status_t'(rd[1:0]), status_write_busy);
			while (done_count == done_before)
				@(posedge clk);
			repeat (4) @(posedge clk);
			check_count("go_transfer", go_count - go_before, 1);
			check_count("transfer_complete", done_count - done_before, 1);
			bus_read(`AVS_ADDR_STATUS, rd);
			check_data("status", rd, 32'h0);
		end
	endtask

	task automatic test_spi_read();
		int go_before;
		int done_before;
		data_t word;
		data_t rd;
		begin
			// clearing the write bit gives no edge
			bus_write(`AVS_ADDR_CONTROL, 32'h0, 1'b1);
			go_before = go_count;
			done_before = done_count;
			arm_engine(word);
			bus_write(`AVS_ADDR_CONTROL, 32'h2, 1'b1);
			while (go_count == go_before)
				@(posedge clk);
			bus_read(`AVS_ADDR_STATUS, rd);
			check_status("status", spi_status_t'(rd[1:0]), status_read_busy);
			while (done_count == done_before)
				@(posedge clk);
			bus_read(`AVS_ADDR_STATUS, rd);
			check_status("status", spi_status_t'(rd[1:0]), status_read_ready);
			// read_ready must hold
			repeat (10) @(posedge clk);
			bus_read(`AVS_ADDR_STATUS, rd);
			check_status("status", spi_status_t'(rd[1:0]), status_read_ready);
			bus_read(`AVS_ADDR_DATA_RD, rd);
			check_data("data_rd", rd, word);
			check_count("go_transfer", go_count - go_before, 1);
			check_count("transfer_complete", done_count - done_before, 1);
		end
	endtask

	task automatic test_ignored();
		int go_before;
		data_t rd;
		begin
			go_before = go_count;
			// read bit still set from the read test
			bus_write(`AVS_ADDR_CONTROL, 32'h2, 1'b1);
			bus_write(`AVS_ADDR_CONTROL, 32'h1, 1'b0);
			bus_write(`AVS_ADDR_DATA_WR, ~tx_expect, 1'b0);
			// both start bits set so an alias onto control would start a write
			bus_write(8'h04, 32'h3, 1'b1);
			repeat (4) @(posedge clk);
			check_count("go_transfer", go_count - go_before, 0);
			check_data("tx_data", spi_req.tx_data, tx_expect);
			bus_read(`AVS_ADDR_STATUS, rd);
			check_status("status", spi_status_t'(rd[1:0]), status_read_ready);
			bus_read(8'h04, rd);
			check_data("unmapped read", rd, 32'h0);
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(32'h79de));
		reset_n = 1'b0;
		avs_req = '0;
		engine_len = 5'd4;
		engine_word = '0;
		tx_expect = '0;
		repeat (10) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);
		test_reset();
		test_data_write();
		test_spi_write();
		test_spi_read();
		test_ignored();
		$display("checks done, %0d errors", err_count);
		if (err_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: avalon_spi_bridge.f
+incdir+design
design/avalon_spi_pkg.sv
design/bus_access_fsm.sv
design/bridge_regs.sv
design/spi_sequencer.sv
design/avalon_spi_bridge.sv
bench/spi_engine_model.sv
bench/tb_avalon_spi_bridge.sv
